// File: fetch_pkg.sv
package fetch_pkg;

  // 4 KB pages
  localparam int page_offset_bits = 12;

  // PTE layout for the single-level table
  localparam int pte_valid_bit = 0;
  localparam int pte_ppn_lsb   = 12;
  localparam int pte_bytes     = 8;  // Walker reads at ptbr + vpn * pte_bytes

  // Sequential PC step
  localparam int instr_bytes = 4;

endpackage

// File: fetch_sequencer.sv
module fetch_sequencer
  import fetch_pkg::*;
#(
  parameter int addr_width  = 64,
  parameter int instr_width = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [addr_width-1:0]  entry,
  input  logic                   branch_taken,
  input  logic [addr_width-1:0]  branch_target,
  input  logic                   flush,
  input  logic [addr_width-1:0]  flush_target,
  input  logic                   enable,
  output logic [addr_width-1:0]  va,
  output logic                   va_req,
  input  logic [addr_width-1:0]  pa,
  input  logic                   pa_valid,
  input  logic                   pa_fault,
  output logic [addr_width-1:0]  cache_addr,
  output logic                   cache_req,
  input  logic [instr_width-1:0] cache_instr,
  input  logic                   cache_valid,
  output logic [instr_width-1:0] instr,
  output logic [addr_width-1:0]  instr_pc,
  output logic [addr_width-1:0]  instr_pc_plus4,
  output logic                   instr_valid,
  output logic                   fault
);
  localparam logic [1:0] s_idle        = 2'd0;
  localparam logic [1:0] s_translating = 2'd1;
  localparam logic [1:0] s_reading     = 2'd2;
  localparam logic [1:0] s_holding     = 2'd3;
  localparam logic [addr_width-1:0] step = addr_width'(instr_bytes);

  logic [1:0]             state;
  logic [1:0]             state_next;
  logic [addr_width-1:0]  pc;        // Next PC to fetch
  logic [addr_width-1:0]  fetch_pc;  // PC of the fetch in flight
  logic [instr_width-1:0] held_instr;
  logic                   stale;
  logic                   redirect;
  logic                   issue;
  logic                   deliver;
  logic                   in_flight;  // Open from va_req until the response that ends the fetch

  assign redirect = flush | branch_taken;
  assign issue    = (state == s_idle) && enable && !fault && !redirect;
  assign deliver  = enable && !redirect &&
                    ((state == s_reading && cache_valid && !stale) || state == s_holding);

  assign va         = fetch_pc;
  assign cache_addr = pa;
  assign cache_req  = pa_valid && (state == s_translating) && !stale;  // Stale ones stop here

  always_comb begin
    state_next = state;
    case (state)
      s_idle:        if (issue) state_next = s_translating;
      s_translating: begin
        if (pa_valid) state_next = stale ? s_idle : s_reading;
        else if (pa_fault) state_next = s_idle;
      end
      s_reading: begin
        if (cache_valid) state_next = (stale || redirect || enable) ? s_idle : s_holding;
      end
      default:       if (enable || redirect) state_next = s_idle;  // Held result leaves or is dropped
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= s_idle;
      pc          <= entry;
      stale       <= 1'b0;
      fault       <= 1'b0;
      va_req      <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      state       <= state_next;
      stale       <= (state_next == s_translating || state_next == s_reading) &&
                     (stale || redirect);
      va_req      <= issue;
      instr_valid <= deliver;
      if (redirect) fault <= 1'b0;
      else if (state == s_translating && pa_fault && !stale) fault <= 1'b1;
      if (flush) pc <= flush_target;  // Flush beats branch
      else if (branch_taken) pc <= branch_target;
      else if (issue) pc <= pc + step;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) fetch_pc <= pc;
    if (state == s_reading && cache_valid) held_instr <= cache_instr;
    if (deliver) begin
      instr          <= (state == s_holding) ? held_instr : cache_instr;
      instr_pc       <= fetch_pc;
      instr_pc_plus4 <= fetch_pc + step;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) in_flight <= 1'b0;
    else if (va_req) in_flight <= 1'b1;
    else if (pa_fault || (pa_valid && !cache_req) || cache_valid) in_flight <= 1'b0;
  end

  // No new translation before the last fetch has ended
  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    va_req |-> !in_flight);

endmodule

// File: fetch_top.f
fetch_pkg.sv
fetch_sequencer.sv
itlb.sv
icache.sv
mem_port_arbiter.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv

// File: fetch_top.sv
module fetch_top #(
  parameter int addr_width     = 64,
  parameter int instr_width    = 32,
  parameter int mem_data_width = 64,
  parameter int tlb_entries    = 8,
  parameter int cache_lines    = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [addr_width-1:0]     entry,
  input  logic [addr_width-1:0]     ptbr,
  input  logic                      branch_taken,
  input  logic [addr_width-1:0]     branch_target,
  input  logic                      flush,
  input  logic [addr_width-1:0]     flush_target,
  input  logic                      enable,
  output logic [instr_width-1:0]    instr,
  output logic [addr_width-1:0]     instr_pc,
  output logic [addr_width-1:0]     instr_pc_plus4,
  output logic                      instr_valid,
  output logic                      fault,
  output logic                      mem_req,
  output logic [addr_width-1:0]     mem_addr,
  input  logic                      mem_rvalid,
  input  logic [mem_data_width-1:0] mem_rdata
);
  logic [addr_width-1:0]     va;
  logic                      va_req;
  logic [addr_width-1:0]     pa;
  logic                      pa_valid;
  logic                      pa_fault;
  logic [addr_width-1:0]     cache_addr;
  logic                      cache_req;
  logic [instr_width-1:0]    cache_instr;
  logic                      cache_valid;
  logic                      walk_req;
  logic [addr_width-1:0]     walk_addr;
  logic                      walk_accept;
  logic                      walk_rvalid;
  logic [mem_data_width-1:0] walk_rdata;
  logic                      fill_req;
  logic [addr_width-1:0]     fill_addr;
  logic                      fill_accept;
  logic                      fill_rvalid;
  logic [mem_data_width-1:0] fill_rdata;

  fetch_sequencer #(.addr_width(addr_width), .instr_width(instr_width)) sequencer_i (
    .clk(clk), .reset(reset), .entry(entry),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .flush(flush), .flush_target(flush_target), .enable(enable),
    .va(va), .va_req(va_req), .pa(pa), .pa_valid(pa_valid), .pa_fault(pa_fault),
    .cache_addr(cache_addr), .cache_req(cache_req),
    .cache_instr(cache_instr), .cache_valid(cache_valid),
    .instr(instr), .instr_pc(instr_pc), .instr_pc_plus4(instr_pc_plus4),
    .instr_valid(instr_valid), .fault(fault)
  );

  itlb #(
    .addr_width(addr_width), .mem_data_width(mem_data_width), .tlb_entries(tlb_entries)
  ) itlb_i (
    .clk(clk), .reset(reset), .ptbr(ptbr), .va(va), .va_req(va_req),
    .pa(pa), .pa_valid(pa_valid), .pa_fault(pa_fault),
    .walk_req(walk_req), .walk_addr(walk_addr), .walk_accept(walk_accept),
    .walk_rvalid(walk_rvalid), .walk_rdata(walk_rdata)
  );

  icache #(
    .addr_width(addr_width), .instr_width(instr_width),
    .mem_data_width(mem_data_width), .cache_lines(cache_lines)
  ) icache_i (
    .clk(clk), .reset(reset), .cache_addr(cache_addr), .cache_req(cache_req),
    .cache_instr(cache_instr), .cache_valid(cache_valid),
    .fill_req(fill_req), .fill_addr(fill_addr), .fill_accept(fill_accept),
    .fill_rvalid(fill_rvalid), .fill_rdata(fill_rdata)
  );

  mem_port_arbiter #(.addr_width(addr_width), .mem_data_width(mem_data_width)) arbiter_i (
    .clk(clk), .reset(reset),
    .walk_req(walk_req), .walk_addr(walk_addr), .walk_accept(walk_accept),
    .walk_rvalid(walk_rvalid), .walk_rdata(walk_rdata),
    .fill_req(fill_req), .fill_addr(fill_addr), .fill_accept(fill_accept),
    .fill_rvalid(fill_rvalid), .fill_rdata(fill_rdata),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
  );

endmodule

// File: icache.sv
module icache
  import fetch_pkg::*;
#(
  parameter int addr_width     = 64,
  parameter int instr_width    = 32,
  parameter int mem_data_width = 64,
  parameter int cache_lines    = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [addr_width-1:0]     cache_addr,
  input  logic                      cache_req,
  output logic [instr_width-1:0]    cache_instr,
  output logic                      cache_valid,
  output logic                      fill_req,
  output logic [addr_width-1:0]     fill_addr,
  input  logic                      fill_accept,
  input  logic                      fill_rvalid,
  input  logic [mem_data_width-1:0] fill_rdata
);
  localparam int offset_bits = $clog2(mem_data_width / 8);
  localparam int half_lsb    = $clog2(instr_bytes);  // Address bit 2 picks the half
  localparam int sel_bits    = offset_bits - half_lsb;
  localparam int index_bits  = $clog2(cache_lines);
  localparam int tag_bits    = addr_width - offset_bits - index_bits;
  localparam logic [1:0] s_idle    = 2'd0;
  localparam logic [1:0] s_request = 2'd1;
  localparam logic [1:0] s_wait    = 2'd2;

  logic [1:0]                state;
  logic [cache_lines-1:0]    valid;
  logic [tag_bits-1:0]       tag_mem  [cache_lines];
  logic [mem_data_width-1:0] data_mem [cache_lines];
  logic [addr_width-1:0]     miss_addr;
  logic [index_bits-1:0]     req_index;
  logic [index_bits-1:0]     miss_index;
  logic [sel_bits-1:0]       req_sel;
  logic [sel_bits-1:0]       miss_sel;
  logic                      hit;

  function automatic logic [instr_width-1:0] pick(input logic [mem_data_width-1:0] line,
                                                  input logic [sel_bits-1:0] sel);
    return line[sel*instr_width +: instr_width];
  endfunction

  assign req_index  = cache_addr[offset_bits +: index_bits];
  assign req_sel    = cache_addr[half_lsb +: sel_bits];
  assign hit        = valid[req_index] &&
                      tag_mem[req_index] == cache_addr[addr_width-1:offset_bits+index_bits];
  assign miss_index = miss_addr[offset_bits +: index_bits];
  assign miss_sel   = miss_addr[half_lsb +: sel_bits];

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= s_idle;
      valid       <= '0;
      fill_req    <= 1'b0;
      cache_valid <= 1'b0;
    end else begin
      cache_valid <= 1'b0;
      case (state)
        s_idle: begin
          if (cache_req && hit) cache_valid <= 1'b1;
          else if (cache_req) begin
            fill_req <= 1'b1;
            state    <= s_request;
          end
        end
        s_request: begin
          if (fill_accept) begin
            fill_req <= 1'b0;
            state    <= s_wait;
          end
        end
        s_wait: begin
          if (fill_rvalid) begin
            valid[miss_index] <= 1'b1;
            cache_valid       <= 1'b1;
            state             <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && cache_req) begin
      miss_addr   <= cache_addr;
      fill_addr   <= {cache_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};  // Whole line
      cache_instr <= pick(data_mem[req_index], req_sel);
    end
    if (state == s_wait && fill_rvalid) begin
      data_mem[miss_index] <= fill_rdata;
      tag_mem[miss_index]  <= miss_addr[addr_width-1:offset_bits+index_bits];
      cache_instr          <= pick(fill_rdata, miss_sel);
    end
  end

endmodule

// File: itlb.sv
module itlb
  import fetch_pkg::*;
#(
  parameter int addr_width     = 64,
  parameter int mem_data_width = 64,
  parameter int tlb_entries    = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [addr_width-1:0]     ptbr,
  input  logic [addr_width-1:0]     va,
  input  logic                      va_req,
  output logic [addr_width-1:0]     pa,
  output logic                      pa_valid,
  output logic                      pa_fault,
  output logic                      walk_req,
  output logic [addr_width-1:0]     walk_addr,
  input  logic                      walk_accept,
  input  logic                      walk_rvalid,
  input  logic [mem_data_width-1:0] walk_rdata
);
  localparam int vpn_bits   = addr_width - page_offset_bits;
  localparam int index_bits = $clog2(tlb_entries);
  localparam int tag_bits   = vpn_bits - index_bits;
  localparam logic [1:0] s_idle    = 2'd0;
  localparam logic [1:0] s_request = 2'd1;
  localparam logic [1:0] s_wait    = 2'd2;

  logic [1:0]             state;
  logic [tlb_entries-1:0] valid;
  logic [tag_bits-1:0]    tag_mem [tlb_entries];
  logic [vpn_bits-1:0]    ppn_mem [tlb_entries];
  logic [addr_width-1:0]  miss_va;
  logic [vpn_bits-1:0]    va_vpn;
  logic [vpn_bits-1:0]    miss_vpn;
  logic [vpn_bits-1:0]    pte_ppn;
  logic [index_bits-1:0]  va_index;
  logic [index_bits-1:0]  miss_index;
  logic                   hit;
  logic                   pte_ok;

  assign va_vpn     = va[addr_width-1:page_offset_bits];
  assign va_index   = va_vpn[index_bits-1:0];
  assign hit        = valid[va_index] && tag_mem[va_index] == va_vpn[vpn_bits-1:index_bits];
  assign miss_vpn   = miss_va[addr_width-1:page_offset_bits];
  assign miss_index = miss_vpn[index_bits-1:0];
  assign pte_ppn    = walk_rdata[pte_ppn_lsb +: vpn_bits];
  assign pte_ok     = walk_rdata[pte_valid_bit];

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= s_idle;
      valid    <= '0;
      walk_req <= 1'b0;
      pa_valid <= 1'b0;
      pa_fault <= 1'b0;
    end else begin
      pa_valid <= 1'b0;
      pa_fault <= 1'b0;
      case (state)
        s_idle: begin
          if (va_req && hit) pa_valid <= 1'b1;
          else if (va_req) begin
            walk_req <= 1'b1;  // Held until the arbiter takes it
            state    <= s_request;
          end
        end
        s_request: begin
          if (walk_accept) begin
            walk_req <= 1'b0;
            state    <= s_wait;
          end
        end
        s_wait: begin
          if (walk_rvalid) begin
            state <= s_idle;
            if (pte_ok) begin
              valid[miss_index] <= 1'b1;
              pa_valid          <= 1'b1;
            end else begin
              pa_fault <= 1'b1;  // Entry left unfilled
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && va_req) begin
      miss_va   <= va;
      walk_addr <= ptbr + addr_width'(va_vpn) * addr_width'(pte_bytes);
      pa        <= {ppn_mem[va_index], va[page_offset_bits-1:0]};
    end
    if (state == s_wait && walk_rvalid && pte_ok) begin
      tag_mem[miss_index] <= miss_vpn[vpn_bits-1:index_bits];
      ppn_mem[miss_index] <= pte_ppn;
      pa                  <= {pte_ppn, miss_va[page_offset_bits-1:0]};
    end
  end

  // Arbiter must route PTE data here only for our own walk
  a_walk_pending: assert property (@(posedge clk) disable iff (reset)
    walk_rvalid |-> state == s_wait);

endmodule

// File: mem_port_arbiter.sv
module mem_port_arbiter #(
  parameter int addr_width     = 64,
  parameter int mem_data_width = 64
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      walk_req,
  input  logic [addr_width-1:0]     walk_addr,
  output logic                      walk_accept,
  output logic                      walk_rvalid,
  output logic [mem_data_width-1:0] walk_rdata,
  input  logic                      fill_req,
  input  logic [addr_width-1:0]     fill_addr,
  output logic                      fill_accept,
  output logic                      fill_rvalid,
  output logic [mem_data_width-1:0] fill_rdata,
  output logic                      mem_req,
  output logic [addr_width-1:0]     mem_addr,
  input  logic                      mem_rvalid,
  input  logic [mem_data_width-1:0] mem_rdata
);
  localparam logic owner_walk = 1'b0;
  localparam logic owner_fill = 1'b1;

  logic busy;   // One access outstanding
  logic owner;

  assign walk_accept = !busy && walk_req;  // Walker wins a tie
  assign fill_accept = !busy && !walk_req && fill_req;
  assign walk_rvalid = mem_rvalid && owner == owner_walk;
  assign fill_rvalid = mem_rvalid && owner == owner_fill;
  assign walk_rdata  = mem_rdata;
  assign fill_rdata  = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      owner   <= owner_walk;
      mem_req <= 1'b0;
    end else begin
      mem_req <= walk_accept || fill_accept;
      if (walk_accept || fill_accept) begin
        busy  <= 1'b1;
        owner <= fill_accept ? owner_fill : owner_walk;
      end else if (mem_rvalid) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (walk_accept) mem_addr <= walk_addr;
    else if (fill_accept) mem_addr <= fill_addr;
  end

  // Response comes at least a cycle after its request
  a_rvalid_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_rvalid |-> busy && !mem_req);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch_top -f fetch_top.f -o tb_fetch_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_fetch_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb_fetch_top.sv
module tb_fetch_top
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          addr_width   = 64;
  localparam int          instr_width  = 32;
  localparam logic [63:0] ptbr_base    = 64'h0080_0000;
  localparam logic [63:0] entry_pc     = 64'h1000;
  localparam logic [51:0] unmapped_vpn = 52'h4;
  localparam int          wait_limit   = 600;

  logic                   clk;
  logic                   reset;
  logic [addr_width-1:0]  entry;
  logic [addr_width-1:0]  ptbr;
  logic                   branch_taken;
  logic [addr_width-1:0]  branch_target;
  logic                   flush;
  logic [addr_width-1:0]  flush_target;
  logic                   enable;
  logic [instr_width-1:0] instr;
  logic [addr_width-1:0]  instr_pc;
  logic [addr_width-1:0]  instr_pc_plus4;
  logic                   instr_valid;
  logic                   fault;
  logic                   mem_req;
  logic [addr_width-1:0]  mem_addr;
  logic                   mem_rvalid;
  logic [63:0]            mem_rdata;
  logic                   mem_pending;
  logic [addr_width-1:0]  exp_pc;  // PC of the next delivery
  logic [instr_width-1:0] exp_instr;
  string                  test_name = "reset";
  int                     value_errors = 0;
  int                     other_failures = 0;
  int                     seed = 23;

  fetch_top #(
    .addr_width(addr_width), .instr_width(instr_width), .mem_data_width(64),
    .tlb_entries(8), .cache_lines(16)
  ) fetch_top_i (
    .clk(clk), .reset(reset), .entry(entry), .ptbr(ptbr),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .flush(flush), .flush_target(flush_target), .enable(enable),
    .instr(instr), .instr_pc(instr_pc), .instr_pc_plus4(instr_pc_plus4),
    .instr_valid(instr_valid), .fault(fault),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
  );

  tb_mem_model #(.addr_width(addr_width), .ptbr_base(ptbr_base)) mem_model_i (
    .clk(clk), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .pending(mem_pending),
    .check_va(exp_pc), .check_instr(exp_instr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reference PC model where a redirect overrides the step of a delivery in the same cycle
  always_ff @(posedge clk) begin
    if (reset) exp_pc <= entry_pc;
    else begin
      if (instr_valid) exp_pc <= exp_pc + 64'(instr_bytes);
      if (flush) exp_pc <= flush_target;
      else if (branch_taken) exp_pc <= branch_target;
    end
  end

  task automatic report_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
    value_errors++;
    $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string what);
    other_failures++;
    $display("Failure in %s: %s", test_name, what);
  endtask

  task automatic wait_deliveries(input int count);
    int seen = 0;
    int cycles = 0;
    while (seen < count && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
      if (instr_valid) seen++;
    end
    if (seen < count) report_failure($sformatf("timed out after %0d of %0d deliveries",
                                               seen, count));
  endtask

  task automatic wait_fault();
    int cycles = 0;
    while (!fault && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!fault) report_failure("fault never rose for the unmapped page");
  endtask

  task automatic redirect(input logic do_branch, input logic [63:0] b_target,
                          input logic do_flush, input logic [63:0] f_target);
    @(posedge clk);
    branch_taken  <= do_branch;
    branch_target <= b_target;
    flush         <= do_flush;
    flush_target  <= f_target;
    @(posedge clk);
    branch_taken <= 1'b0;
    flush        <= 1'b0;
  endtask

  task automatic stall(input int cycles);
    @(posedge clk);
    enable <= 1'b0;
    repeat (cycles) @(posedge clk);
    enable <= 1'b1;
  endtask

  a_pc: assert property (@(posedge clk) disable iff (reset) instr_valid |-> instr_pc == exp_pc)
    else report_value("instr_pc", $sampled(exp_pc), $sampled(instr_pc));
  a_pc_plus4: assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> instr_pc_plus4 == exp_pc + 64'(instr_bytes))
    else report_value("instr_pc_plus4", $sampled(exp_pc) + 64'(instr_bytes),
                      $sampled(instr_pc_plus4));
  a_instr: assert property (@(posedge clk) disable iff (reset) instr_valid |-> instr == exp_instr)
    else report_value("instr", 64'($sampled(exp_instr)), 64'($sampled(instr)));
  a_hold_valid: assert property (@(posedge clk) disable iff (reset) !enable |=> !instr_valid)
    else report_failure("instr_valid pulsed while enable was low");
  a_hold_data: assert property (@(posedge clk) disable iff (reset)
    !enable |=> $stable(instr) && $stable(instr_pc) && $stable(instr_pc_plus4))
    else report_failure("output register changed while enable was low");
  a_fault_quiet: assert property (@(posedge clk) disable iff (reset) fault |-> !instr_valid)
    else report_failure("instr_valid pulsed while fault was set");
  a_fault_page: assert property (@(posedge clk) disable iff (reset)
    $rose(fault) |-> exp_pc[63:12] == unmapped_vpn)
    else report_value("fault page", 64'(unmapped_vpn), $sampled(exp_pc) >> 12);
  a_fault_clear: assert property (@(posedge clk) disable iff (reset) flush |=> !fault)
    else report_failure("fault stayed set after a flush");
  a_mem_rule: assert property (@(posedge clk) disable iff (reset) mem_req |-> !mem_pending)
    else report_failure("mem_req pulsed while an access was outstanding");
  // PTE reads and line refills both fetch whole 64-bit words
  a_mem_align: assert property (@(posedge clk) disable iff (reset)
    mem_req |-> mem_addr[2:0] == 3'd0)
    else report_value("mem_addr low bits", 64'd0, 64'($sampled(mem_addr[2:0])));

  initial begin
    logic [63:0] target;
    reset         <= 1'b1;
    entry         <= entry_pc;
    ptbr          <= ptbr_base;
    branch_taken  <= 1'b0;
    branch_target <= '0;
    flush         <= 1'b0;
    flush_target  <= '0;
    enable        <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    test_name = "sequential";
    wait_deliveries(10);
    for (int loop = 0; loop < 3; loop++) begin
      redirect(1'b1, entry_pc, 1'b0, '0);  // Same lines again now hit
      wait_deliveries(10);
    end
    redirect(1'b1, 64'h1ff0, 1'b0, '0);  // Runs into the next page
    wait_deliveries(8);

    test_name = "branch";
    for (int i = 0; i < 6; i++) begin
      target = 64'h1000 + 64'(($unsigned($random(seed)) % 32'h2f00) & 32'hffff_fffc);
      repeat ($unsigned($random(seed)) % 5) @(posedge clk);
      redirect(1'b1, target, 1'b0, '0);
      wait_deliveries(3);
    end

    test_name = "flush_priority";
    for (int i = 0; i < 3; i++) begin
      repeat ($unsigned($random(seed)) % 4) @(posedge clk);
      redirect(1'b1, 64'h1100, 1'b1, 64'h2800 + 64'(i * 16));
      wait_deliveries(4);
    end

    test_name = "back_pressure";
    for (int i = 0; i < 6; i++) begin
      stall(2 + int'($unsigned($random(seed)) % 7));
      wait_deliveries(2);
    end

    test_name = "fault";
    redirect(1'b1, 64'h3ff0, 1'b0, '0);
    wait_fault();
    repeat (5) @(posedge clk);
    redirect(1'b0, '0, 1'b1, 64'h1200);
    wait_deliveries(6);

    repeat (5) @(posedge clk);
    $display("Checks done with %0d value errors and %0d other failures",
             value_errors, other_failures);
    if (value_errors == 0 && other_failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb_mem_model.sv
module tb_mem_model
  import fetch_pkg::*;
#(
  parameter int              addr_width = 64,
  parameter logic [63:0]     ptbr_base  = 64'h0080_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  mem_req,
  input  logic [addr_width-1:0] mem_addr,
  output logic                  mem_rvalid,
  output logic [63:0]           mem_rdata,
  output logic                  pending,
  input  logic [addr_width-1:0] check_va,
  output logic [31:0]           check_instr
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int vpn_bits = addr_width - page_offset_bits;

  int                    seed = 23;
  logic [2:0]            delay;
  logic [addr_width-1:0] req_addr;

  // Virtual pages 1 to 3 land on scattered frames and page 4 has no mapping
  function automatic logic [vpn_bits-1:0] phys_page(input logic [vpn_bits-1:0] vpn);
    case (vpn)
      52'h1:   return 52'h2a7;
      52'h2:   return 52'h13c;
      52'h3:   return 52'h0f5;
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] code_word(input logic [addr_width-1:0] pa);
    return pa[31:0] * 32'h9e37_79b9 ^ pa[63:32] ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [63:0] read_line(input logic [addr_width-1:0] addr);
    logic [vpn_bits-1:0] vpn;
    logic [63:0]         ppn;
    if (addr >= ptbr_base && addr < ptbr_base + 64'h1000) begin
      vpn = vpn_bits'((addr - ptbr_base) / 64'(pte_bytes));
      ppn = 64'(phys_page(vpn));
      if (ppn == 64'd0) return 64'd0;  // Invalid PTE
      return (ppn << pte_ppn_lsb) | (64'd1 << pte_valid_bit);
    end
    return {code_word(addr + 64'd4), code_word(addr)};
  endfunction

  assign check_instr = code_word({phys_page(check_va[addr_width-1:page_offset_bits]),
                                  check_va[page_offset_bits-1:0]});

  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      mem_rvalid <= 1'b0;
      mem_rdata  <= '0;
      delay      <= 3'd0;
    end else begin
      mem_rvalid <= 1'b0;
      if (mem_req) begin
        pending  <= 1'b1;
        req_addr <= mem_addr;
        delay    <= 3'($unsigned($random(seed)) % 32'd6);  // Answer in 1 to 6 cycles
      end else if (pending) begin
        if (delay == 3'd0) begin
          mem_rvalid <= 1'b1;
          mem_rdata  <= read_line(req_addr);
          pending    <= 1'b0;
        end else begin
          delay <= delay - 3'd1;
        end
      end
    end
  end

endmodule
